// File: Makefile
TOP = tb_frame_switch

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f flist.f -o V$(TOP)

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir

// File: arb_pkg.sv
`default_nettype none

`include "bus_settings.svh"

package arb_pkg;

	// One of the four bus nodes
	typedef logic [1:0] node_idx_t;

	// Slave bus arbiter states
	typedef enum logic [1:0] {
		IDLE,
		GRANT,
		RELEASE
	} arb_state_e;

	// FIFO pointer with an extra wrap bit so full and empty differ
	typedef logic [$clog2(`FIFO_DEPTH):0] ptr_t;

endpackage

`default_nettype wire

// File: bus_interface.sv
`default_nettype none

`include "bus_settings.svh"

module bus_interface #(
	parameter logic [7:0] ADDR = 8'h00,
	parameter bit INCLUDE_INPUT_FIFO = 1'b0,
	parameter bit INCLUDE_OUTPUT_FIFO = 1'b0
) (
	input  wire                        clk,
	input  wire                        arst_n,

	// Master bus
	input  wire [7:0]                  ma_data,
	input  wire [7:0]                  ma_addr,
	input  wire                        ma_data_valid,
	input  wire                        ma_frame_valid,
	output logic                       overflow,

	// Slave bus
	input  wire frame_pkg::word_idx_t  sl_addr,
	input  wire                        sl_latch_tail,
	input  wire                        sl_arb_grant,
	output frame_pkg::bus_word_u       sl_data,
	output frame_pkg::word_idx_t       sl_tail,
	output logic                       sl_arb_request,

	// Local consumer
	input  wire frame_pkg::word_idx_t  in_frame_addr,
	input  wire                        in_frame_latch_tail,
	output frame_pkg::fifo_word_t      in_frame_data,
	output frame_pkg::word_idx_t       in_frame_tail,
	output logic                       in_frame_valid,

	// Local producer
	input  wire [7:0]                  out_frame_data,
	input  wire                        out_frame_valid,
	input  wire                        out_frame_data_latch
);

	logic addr_match;
	logic rx_frame;
	logic rx_write;
	logic has_frame;
	logic pop;
	logic pop_q;

	assign addr_match = (ma_addr == ADDR);
	assign rx_frame = ma_frame_valid && addr_match;
	assign rx_write = ma_data_valid && rx_frame;

	// Return to zero: request drops for a cycle after every pop
	assign pop = sl_latch_tail && sl_arb_grant && sl_arb_request;
	assign sl_arb_request = has_frame && !pop_q;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pop_q <= 1'b0;
		end else begin
			pop_q <= pop;
		end
	end

	if (INCLUDE_INPUT_FIFO) begin : g_in_fifo
		message_fifo #(
			.WIDTH(9)
		) in_fifo_i (
			.clk(clk),
			.arst_n(arst_n),
			.in_data(ma_data),
			.in_data_latch(rx_write),
			.in_frame_valid(rx_frame),
			.in_data_overflow(overflow),
			.out_data_addr(in_frame_addr),
			.latch_tail(in_frame_latch_tail),
			.out_data(in_frame_data),
			.tail(in_frame_tail),
			.out_frame_valid(in_frame_valid)
		);
	end else begin : g_in_bypass
		// Bytes go straight to the consumer, nothing is stored
		assign overflow = 1'b0;
		assign in_frame_data = '{last: 1'b0, data: ma_data};
		assign in_frame_tail = '0;
		assign in_frame_valid = rx_frame;
	end

	if (INCLUDE_OUTPUT_FIFO) begin : g_out_fifo
		frame_pkg::fifo_word_t tx_word;

		message_fifo #(
			.WIDTH(9)
		) out_fifo_i (
			.clk(clk),
			.arst_n(arst_n),
			.in_data(out_frame_data),
			.in_data_latch(out_frame_data_latch),
			.in_frame_valid(out_frame_valid),
			.in_data_overflow(),
			.out_data_addr(sl_addr),
			.latch_tail(pop),
			.out_data(tx_word),
			.tail(sl_tail),
			.out_frame_valid(has_frame)
		);

		always_comb begin
			sl_data.data.last = tx_word.last;
			sl_data.data.data = tx_word.data;
		end
	end else begin : g_status
		localparam logic [2:0] SRC = 3'(ADDR - `NODE_ADDR_BASE);

		logic rx_fv_q;
		logic rx_end;
		logic st_valid;
		frame_pkg::word_idx_t rx_cnt;
		frame_pkg::word_idx_t rx_len;
		frame_pkg::bus_word_u st_word;

		assign rx_end = rx_fv_q && !rx_frame;

		// The write that overflowed was counted but not stored
		assign rx_len = rx_cnt - frame_pkg::word_idx_t'(overflow);

		always_ff @(posedge clk or negedge arst_n) begin
			if (!arst_n) begin
				rx_fv_q <= 1'b0;
				rx_cnt <= '0;
				st_valid <= 1'b0;
			end else begin
				rx_fv_q <= rx_frame;
				if (rx_end) begin
					rx_cnt <= '0;
				end else if (rx_write && !overflow) begin
					rx_cnt <= rx_cnt + 1'b1;
				end
				// A newer frame replaces an unsent status word
				if (rx_end) begin
					st_valid <= 1'b1;
				end else if (pop) begin
					st_valid <= 1'b0;
				end
			end
		end

		always_ff @(posedge clk) begin
			if (rx_end) begin
				st_word.status.last <= 1'b1;
				st_word.status.ack <= !overflow;
				st_word.status.src <= SRC;
				// Length saturates at 15
				st_word.status.len <= (rx_len > 9'd15) ? 4'hf : rx_len[3:0];
			end
		end

		assign has_frame = st_valid;
		assign sl_data = st_word;
		assign sl_tail = frame_pkg::word_idx_t'(1);
	end

	a_pop_while_requesting: assert property (@(posedge clk) disable iff (!arst_n)
		sl_latch_tail && sl_arb_grant |-> sl_arb_request);

endmodule

`default_nettype wire

// File: bus_settings.svh
`ifndef BUS_SETTINGS_SVH
`define BUS_SETTINGS_SVH

// Number of nodes on the shared buses
`define NODE_COUNT 4

// Words held by each message FIFO
`define FIFO_DEPTH 16

// Master bus address of node 0, node n answers at base + n
`define NODE_ADDR_BASE 8'h10

// Per-node FIFO builds, bit n belongs to node n
// Node 2 keeps only an ACK/NAK word, node 3 passes input bytes straight through
`define INPUT_FIFO_MASK 4'b0111
`define OUTPUT_FIFO_MASK 4'b1011

`endif

// File: flist.f
+incdir+.
frame_pkg.sv
arb_pkg.sv
message_fifo.sv
bus_interface.sv
slave_arbiter.sv
frame_switch.sv
tb_frame_switch.sv

// File: frame_pkg.sv
`default_nettype none

package frame_pkg;

	// Word offset inside a frame, also used for frame lengths
	typedef logic [8:0] word_idx_t;

	// Word as kept in a message FIFO
	typedef struct packed {
		logic       last;
		logic [7:0] data;
	} fifo_word_t;

	// Slave bus word that carries a frame byte
	typedef struct packed {
		logic       last;
		logic [7:0] data;
	} data_view_t;

	// Slave bus word that reports one received frame
	// ack low means bytes were dropped
	typedef struct packed {
		logic       last;
		logic       ack;
		logic [2:0] src;
		logic [3:0] len;
	} status_view_t;

	// Host picks the view from the source node
	typedef union packed {
		data_view_t   data;
		status_view_t status;
	} bus_word_u;

endpackage

`default_nettype wire

// File: frame_switch.sv
`default_nettype none

`include "bus_settings.svh"

module frame_switch (
	input  wire                                             clk,
	input  wire                                             arst_n,

	// Master bus
	input  wire [7:0]                                       ma_data,
	input  wire [7:0]                                       ma_addr,
	input  wire                                             ma_data_valid,
	input  wire                                             ma_frame_valid,
	output logic                                            sl_overflow,

	// Slave bus
	input  wire frame_pkg::word_idx_t                       sl_addr,
	input  wire                                             sl_latch_tail,
	output frame_pkg::bus_word_u                            sl_data,
	output frame_pkg::word_idx_t                            sl_tail,
	output arb_pkg::node_idx_t                              sl_src,
	output logic                                            sl_valid,

	// Local consumers, one lane per node
	input  wire frame_pkg::word_idx_t [`NODE_COUNT-1:0]     in_frame_addr,
	input  wire [`NODE_COUNT-1:0]                           in_frame_latch_tail,
	output frame_pkg::fifo_word_t [`NODE_COUNT-1:0]         in_frame_data,
	output frame_pkg::word_idx_t [`NODE_COUNT-1:0]          in_frame_tail,
	output logic [`NODE_COUNT-1:0]                          in_frame_valid,

	// Local producers, one lane per node
	input  wire [`NODE_COUNT-1:0][7:0]                      out_frame_data,
	input  wire [`NODE_COUNT-1:0]                           out_frame_valid,
	input  wire [`NODE_COUNT-1:0]                           out_frame_data_latch
);

	localparam int N = `NODE_COUNT;
	localparam logic [N-1:0] IN_MASK = `INPUT_FIFO_MASK;
	localparam logic [N-1:0] OUT_MASK = `OUTPUT_FIFO_MASK;

	logic [N-1:0] node_ovf;
	logic [N-1:0] node_req;
	logic [N-1:0] node_grant;
	frame_pkg::bus_word_u [N-1:0] node_data;
	frame_pkg::word_idx_t [N-1:0] node_tail;

	for (genvar n = 0; n < N; n++) begin : g_node
		bus_interface #(
			.ADDR(8'(`NODE_ADDR_BASE + n)),
			.INCLUDE_INPUT_FIFO(IN_MASK[n]),
			.INCLUDE_OUTPUT_FIFO(OUT_MASK[n])
		) bus_interface_i (
			.clk(clk),
			.arst_n(arst_n),
			.ma_data(ma_data),
			.ma_addr(ma_addr),
			.ma_data_valid(ma_data_valid),
			.ma_frame_valid(ma_frame_valid),
			.overflow(node_ovf[n]),
			.sl_addr(sl_addr),
			.sl_latch_tail(sl_latch_tail),
			.sl_arb_grant(node_grant[n]),
			.sl_data(node_data[n]),
			.sl_tail(node_tail[n]),
			.sl_arb_request(node_req[n]),
			.in_frame_addr(in_frame_addr[n]),
			.in_frame_latch_tail(in_frame_latch_tail[n]),
			.in_frame_data(in_frame_data[n]),
			.in_frame_tail(in_frame_tail[n]),
			.in_frame_valid(in_frame_valid[n]),
			.out_frame_data(out_frame_data[n]),
			.out_frame_valid(out_frame_valid[n]),
			.out_frame_data_latch(out_frame_data_latch[n])
		);
	end

	slave_arbiter slave_arbiter_i (
		.clk(clk),
		.arst_n(arst_n),
		.req(node_req),
		.node_data(node_data),
		.node_tail(node_tail),
		.grant(node_grant),
		.sl_data(sl_data),
		.sl_tail(sl_tail),
		.sl_src(sl_src),
		.sl_valid(sl_valid)
	);

	// Overflow of the addressed node, low for unowned addresses
	always_comb begin
		sl_overflow = 1'b0;
		for (int n = 0; n < N; n++) begin
			if (ma_addr == 8'(`NODE_ADDR_BASE + n)) begin
				sl_overflow = node_ovf[n];
			end
		end
	end

endmodule

`default_nettype wire

// File: frame_testdata.txt
# T name | S addr n bytes | I node n bytes | P node n bytes | D | B src n words | Z
# addr, bytes and 9-bit slave words in hex; node and n in decimal
T delivery
S 10 4 a1 a2 a3 a4
S 11 3 b1 b2 b3
I 0 4 a1 a2 a3 a4
I 1 3 b1 b2 b3
S 12 2 c1 c2
B 2 1 1a2
I 2 2 c1 c2
S 10 1 5e
S 10 5 01 02 03 04 05
I 0 1 5e
I 0 5 01 02 03 04 05
Z
T filter
S 2a 4 de ad be ef
S 14 3 77 88 99
Z
T passthrough
S 13 6 10 20 30 40 50 60
Z
T slave_order
P 0 3 11 12 13
P 1 2 21 22
P 3 4 31 32 33 34
D
P 0 2 41 42
P 3 1 51
D
P 1 5 61 62 63 64 65
D
Z
T overflow
S 12 10 00 01 02 03 04 05 06 07 08 09
B 2 1 1aa
S 12 8 e0 e1 e2 e3 e4 e5 e6 e7
B 2 1 126
I 2 10 00 01 02 03 04 05 06 07 08 09
I 2 6 e0 e1 e2 e3 e4 e5
Z

// File: message_fifo.sv
`default_nettype none

`include "bus_settings.svh"

module message_fifo #(
	parameter int WIDTH = 9
) (
	input  wire                        clk,
	input  wire                        arst_n,

	// Write side
	input  wire [WIDTH-2:0]            in_data,
	input  wire                        in_data_latch,
	input  wire                        in_frame_valid,
	output logic                       in_data_overflow,

	// Read side
	input  wire frame_pkg::word_idx_t  out_data_addr,
	input  wire                        latch_tail,
	output logic [WIDTH-1:0]           out_data,
	output frame_pkg::word_idx_t       tail,
	output logic                       out_frame_valid
);

	localparam int DEPTH = `FIFO_DEPTH;
	localparam int AW = $clog2(DEPTH);

	logic [WIDTH-1:0] mem [DEPTH];
	frame_pkg::word_idx_t len_q [DEPTH];

	arb_pkg::ptr_t wr_ptr;
	arb_pkg::ptr_t com_ptr;
	arb_pkg::ptr_t rd_ptr;
	arb_pkg::ptr_t lq_wr;
	arb_pkg::ptr_t lq_rd;
	arb_pkg::ptr_t used;
	arb_pkg::ptr_t pend_len;

	logic fv_q;
	logic ovf_q;
	logic full;
	logic wr_req;
	logic wr_en;
	logic wr_drop;
	logic frame_end;
	logic commit;
	logic pop;
	logic [AW-1:0] last_idx;
	logic [AW-1:0] rd_idx;

	assign used = wr_ptr - rd_ptr;
	assign full = (used == arb_pkg::ptr_t'(DEPTH));
	assign pend_len = wr_ptr - com_ptr;

	// Once a byte is dropped the rest of the frame is dropped too
	assign wr_req = in_data_latch && in_frame_valid && !ovf_q;
	assign wr_en = wr_req && !full;
	assign wr_drop = wr_req && full;

	// Frame is committed on the first idle cycle after its span
	assign frame_end = fv_q && !in_frame_valid;
	assign commit = frame_end && (pend_len != '0);
	assign last_idx = wr_ptr[AW-1:0] - 1'b1;

	assign pop = latch_tail && out_frame_valid;

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_ptr[AW-1:0]] <= {1'b0, in_data};
		end
		if (commit) begin
			mem[last_idx][WIDTH-1] <= 1'b1;
			len_q[lq_wr[AW-1:0]] <= frame_pkg::word_idx_t'(pend_len);
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			com_ptr <= '0;
			rd_ptr <= '0;
			lq_wr <= '0;
			lq_rd <= '0;
			fv_q <= 1'b0;
			ovf_q <= 1'b0;
		end else begin
			fv_q <= in_frame_valid;
			if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			// Overflow stays visible until the frame is closed
			if (wr_drop) begin
				ovf_q <= 1'b1;
			end else if (frame_end) begin
				ovf_q <= 1'b0;
			end
			if (commit) begin
				com_ptr <= wr_ptr;
				lq_wr <= lq_wr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + arb_pkg::ptr_t'(tail);
				lq_rd <= lq_rd + 1'b1;
			end
		end
	end

	// Random access inside the head frame
	assign rd_idx = rd_ptr[AW-1:0] + out_data_addr[AW-1:0];
	assign out_data = mem[rd_idx];
	assign tail = len_q[lq_rd[AW-1:0]];
	assign out_frame_valid = (lq_wr != lq_rd);
	assign in_data_overflow = ovf_q;

	a_pop_needs_frame: assert property (@(posedge clk) disable iff (!arst_n)
		latch_tail |-> out_frame_valid);

	a_commit_behind_write: assert property (@(posedge clk) disable iff (!arst_n)
		pend_len <= arb_pkg::ptr_t'(DEPTH));

endmodule

`default_nettype wire

// File: slave_arbiter.sv
`default_nettype none

`include "bus_settings.svh"

module slave_arbiter (
	input  wire                                         clk,
	input  wire                                         arst_n,

	input  wire [`NODE_COUNT-1:0]                       req,
	input  wire frame_pkg::bus_word_u [`NODE_COUNT-1:0] node_data,
	input  wire frame_pkg::word_idx_t [`NODE_COUNT-1:0] node_tail,

	output logic [`NODE_COUNT-1:0]                      grant,
	output frame_pkg::bus_word_u                        sl_data,
	output frame_pkg::word_idx_t                        sl_tail,
	output arb_pkg::node_idx_t                          sl_src,
	output logic                                        sl_valid
);

	localparam int NODES = 2 ** $bits(arb_pkg::node_idx_t);

	arb_pkg::arb_state_e state_q;
	arb_pkg::node_idx_t cur_q;
	arb_pkg::node_idx_t pick_idx;
	logic pick_valid;

	// Rotating priority that starts just after the last grant
	always_comb begin
		arb_pkg::node_idx_t cand;
		pick_valid = 1'b0;
		pick_idx = cur_q;
		for (int i = 1; i <= NODES; i++) begin
			cand = cur_q + arb_pkg::node_idx_t'(i);
			if (!pick_valid && req[cand]) begin
				pick_valid = 1'b1;
				pick_idx = cand;
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state_q <= arb_pkg::IDLE;
			// Node 0 has first priority after reset
			cur_q <= arb_pkg::node_idx_t'(NODES - 1);
		end else begin
			case (state_q)
				arb_pkg::IDLE: begin
					if (pick_valid) begin
						state_q <= arb_pkg::GRANT;
						cur_q <= pick_idx;
					end
				end
				arb_pkg::GRANT: begin
					if (!req[cur_q]) begin
						state_q <= arb_pkg::RELEASE;
					end
				end
				arb_pkg::RELEASE: begin
					state_q <= arb_pkg::IDLE;
				end
				default: begin
					state_q <= arb_pkg::IDLE;
				end
			endcase
		end
	end

	always_comb begin
		grant = '0;
		sl_data = '0;
		sl_tail = '0;
		sl_src = '0;
		if (state_q == arb_pkg::GRANT) begin
			grant[cur_q] = 1'b1;
			sl_data = node_data[cur_q];
			sl_tail = node_tail[cur_q];
			sl_src = cur_q;
		end
	end

	assign sl_valid = (state_q == arb_pkg::GRANT);

	// A waiting node keeps its request until it is served
	a_req_held: assert property (@(posedge clk) disable iff (!arst_n)
		($past(req & ~grant) & ~req) == '0);

endmodule

`default_nettype wire

// File: tb_frame_switch.sv
`default_nettype none

`include "bus_settings.svh"

module tb_frame_switch;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int N = `NODE_COUNT;
	localparam int DEPTH = `FIFO_DEPTH;
	localparam logic [N-1:0] IN_MASK = `INPUT_FIFO_MASK;
	localparam logic [N-1:0] OUT_MASK = `OUTPUT_FIFO_MASK;
	localparam logic [7:0] BASE = `NODE_ADDR_BASE;

	logic clk = 1'b0;
	logic arst_n;
	logic [7:0] ma_data;
	logic [7:0] ma_addr;
	logic ma_data_valid;
	logic ma_frame_valid;
	logic sl_overflow;
	frame_pkg::word_idx_t sl_addr;
	logic sl_latch_tail;
	frame_pkg::bus_word_u sl_data;
	frame_pkg::word_idx_t sl_tail;
	arb_pkg::node_idx_t sl_src;
	logic sl_valid;
	frame_pkg::word_idx_t [N-1:0] in_frame_addr;
	logic [N-1:0] in_frame_latch_tail;
	frame_pkg::fifo_word_t [N-1:0] in_frame_data;
	frame_pkg::word_idx_t [N-1:0] in_frame_tail;
	logic [N-1:0] in_frame_valid;
	logic [N-1:0][7:0] out_frame_data;
	logic [N-1:0] out_frame_valid;
	logic [N-1:0] out_frame_data_latch;

	// Host view of what each node should hold
	int occ [N];
	int frames [N];
	logic status_pend;
	int last_grant;
	logic [7:0] data_buf [64];
	logic [8:0] exp_w [64];
	logic [7:0] pbuf [N][64];
	int plen [N];
	logic [N-1:0] staged;

	string cur_test;
	int test_err;
	int err_total;
	int tests_pass;
	int tests_fail;
	int cycles = 0;
	int cycle_limit = 0;
	integer seed = 44;

	frame_switch frame_switch_i (
		.clk(clk),
		.arst_n(arst_n),
		.ma_data(ma_data),
		.ma_addr(ma_addr),
		.ma_data_valid(ma_data_valid),
		.ma_frame_valid(ma_frame_valid),
		.sl_overflow(sl_overflow),
		.sl_addr(sl_addr),
		.sl_latch_tail(sl_latch_tail),
		.sl_data(sl_data),
		.sl_tail(sl_tail),
		.sl_src(sl_src),
		.sl_valid(sl_valid),
		.in_frame_addr(in_frame_addr),
		.in_frame_latch_tail(in_frame_latch_tail),
		.in_frame_data(in_frame_data),
		.in_frame_tail(in_frame_tail),
		.in_frame_valid(in_frame_valid),
		.out_frame_data(out_frame_data),
		.out_frame_valid(out_frame_valid),
		.out_frame_data_latch(out_frame_data_latch)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
	end

	task report_mismatch(input string sig, input logic [15:0] exp, input logic [15:0] got);
		$display("error at %0t ns: %s expected %0h got %0h", $time, sig, exp, got);
		test_err++;
	endtask

	task report_problem(input string msg);
		$display("%s (at %0t ns)", msg, $time);
		test_err++;
	endtask

	task close_test;
		if (test_err == 0) begin
			$display("test %s: passed", cur_test);
			tests_pass++;
		end else begin
			$display("test %s: failed with %0d errors", cur_test, test_err);
			tests_fail++;
		end
		err_total += test_err;
		test_err = 0;
		cur_test = "";
	endtask

	task idle_gap;
		repeat ($unsigned($random(seed)) % 4) @(posedge clk);
	endtask

	task check_reset_outputs;
		if (sl_valid !== 1'b0) report_mismatch("sl_valid", 0, sl_valid);
		if (in_frame_valid !== '0) report_mismatch("in_frame_valid", 0, in_frame_valid);
		if (sl_overflow !== 1'b0) report_mismatch("sl_overflow", 0, sl_overflow);
	endtask

	task read_bytes(input int fd, input int n);
		int i;
		int b;
		int r;
		for (i = 0; i < n; i++) begin
			r = $fscanf(fd, " %h", b);
			data_buf[i] = b[7:0];
		end
	endtask

	// Only held frames and an unsent status word may show
	task check_quiet;
		int k;
		logic [N-1:0] exp_fv;
		repeat (4) @(posedge clk);
		@(negedge clk);
		for (k = 0; k < N; k++) begin
			exp_fv[k] = (frames[k] > 0);
		end
		if (in_frame_valid !== exp_fv) report_mismatch("in_frame_valid", exp_fv, in_frame_valid);
		if (sl_valid !== status_pend) report_mismatch("sl_valid", status_pend, sl_valid);
		// Each node's overflow flag ends with its frame
		for (k = 0; k < N; k++) begin
			@(posedge clk);
			ma_addr <= BASE + 8'(k);
			@(negedge clk);
			if (sl_overflow !== 1'b0) begin
				report_mismatch($sformatf("sl_overflow[%0d]", k), 0, sl_overflow);
			end
		end
		@(posedge clk);
		ma_addr <= 8'h00;
	endtask

	task send_frame(input logic [7:0] addr, input int n);
		int i;
		int j;
		int k;
		int stored;
		logic owned;
		logic exp_ovf;
		logic exp_v;
		k = int'(addr) - int'(BASE);
		owned = (k >= 0 && k < N);
		exp_ovf = 1'b0;
		stored = 0;
		if (owned && IN_MASK[k]) begin
			exp_ovf = (n > DEPTH - occ[k]);
			stored = exp_ovf ? DEPTH - occ[k] : n;
		end
		@(posedge clk);
		ma_addr <= addr;
		ma_frame_valid <= 1'b1;
		for (i = 0; i < n; i++) begin
			@(posedge clk);
			ma_data <= data_buf[i];
			ma_data_valid <= 1'b1;
			@(negedge clk);
			// Nodes without an input FIFO mirror the bus while addressed
			for (j = 0; j < N; j++) begin
				exp_v = owned && (k == j);
				if (!IN_MASK[j] && in_frame_valid[j] !== exp_v) begin
					report_mismatch($sformatf("in_frame_valid[%0d]", j), exp_v, in_frame_valid[j]);
				end
				if (!IN_MASK[j] && exp_v && in_frame_data[j].data !== data_buf[i]) begin
					report_mismatch($sformatf("in_frame_data[%0d]", j), data_buf[i],
						in_frame_data[j].data);
				end
			end
		end
		@(posedge clk);
		ma_data_valid <= 1'b0;
		@(negedge clk);
		if (sl_overflow !== exp_ovf) report_mismatch("sl_overflow", exp_ovf, sl_overflow);
		@(posedge clk);
		ma_frame_valid <= 1'b0;
		ma_addr <= 8'h00;
		ma_data <= 8'h00;
		if (owned && IN_MASK[k]) begin
			occ[k] += stored;
			if (stored > 0) frames[k]++;
		end
		if (owned && !OUT_MASK[k]) status_pend = 1'b1;
	endtask

	task expect_input(input int k, input int n);
		int i;
		@(negedge clk);
		while (in_frame_valid[k] !== 1'b1) @(negedge clk);
		if (in_frame_tail[k] !== n) report_mismatch("in_frame_tail", n, in_frame_tail[k]);
		for (i = 0; i < n; i++) begin
			@(posedge clk);
			in_frame_addr[k] <= frame_pkg::word_idx_t'(i);
			@(negedge clk);
			if (in_frame_data[k] !== {i == n - 1, data_buf[i]}) begin
				report_mismatch($sformatf("in_frame_data[%0d]", k), {i == n - 1, data_buf[i]},
					in_frame_data[k]);
			end
		end
		@(posedge clk);
		in_frame_latch_tail[k] <= 1'b1;
		in_frame_addr[k] <= '0;
		@(posedge clk);
		in_frame_latch_tail[k] <= 1'b0;
		occ[k] -= n;
		frames[k]--;
	endtask

	// Reads one granted frame, pops it and waits for the grant to drop
	task expect_slave(input int src, input int n);
		int i;
		@(negedge clk);
		while (sl_valid !== 1'b1) @(negedge clk);
		if (sl_src !== arb_pkg::node_idx_t'(src)) report_mismatch("sl_src", src, sl_src);
		if (sl_tail !== n) report_mismatch("sl_tail", n, sl_tail);
		for (i = 0; i < n; i++) begin
			@(posedge clk);
			sl_addr <= frame_pkg::word_idx_t'(i);
			@(negedge clk);
			if (sl_data !== exp_w[i]) report_mismatch("sl_data", exp_w[i], sl_data);
		end
		@(posedge clk);
		sl_latch_tail <= 1'b1;
		sl_addr <= '0;
		@(posedge clk);
		sl_latch_tail <= 1'b0;
		@(negedge clk);
		while (sl_valid !== 1'b0) @(negedge clk);
		last_grant = src;
		if (!OUT_MASK[src]) status_pend = 1'b0;
	endtask

	task drive_and_drain;
		int i;
		int k;
		int step;
		int nxt;
		int maxlen;
		logic [N-1:0] pending;
		maxlen = 0;
		for (k = 0; k < N; k++) begin
			if (staged[k] && plen[k] > maxlen) maxlen = plen[k];
		end
		// All staged frames commit on the same edge
		@(posedge clk);
		out_frame_valid <= staged;
		for (i = 0; i < maxlen; i++) begin
			@(posedge clk);
			for (k = 0; k < N; k++) begin
				out_frame_data[k] <= pbuf[k][i];
				out_frame_data_latch[k] <= staged[k] && (i < plen[k]);
			end
		end
		@(posedge clk);
		out_frame_data_latch <= '0;
		@(posedge clk);
		out_frame_valid <= '0;
		pending = staged;
		staged = '0;
		while (pending != '0) begin
			// First pending node after the last grant
			nxt = -1;
			for (step = 1; step <= N; step++) begin
				k = (last_grant + step) % N;
				if (nxt < 0 && pending[k]) nxt = k;
			end
			for (i = 0; i < plen[nxt]; i++) begin
				exp_w[i] = {i == plen[nxt] - 1, pbuf[nxt][i]};
			end
			expect_slave(nxt, plen[nxt]);
			pending[nxt] = 1'b0;
		end
	endtask

	initial begin : watchdog
		wait (cycle_limit > 0);
		wait (cycles >= cycle_limit);
		$display("timeout: the data file was not finished within %0d cycles", cycle_limit);
		$display("TEST FAILED");
		$finish;
	end

	initial begin : main
		int fd;
		int r;
		int a;
		int k;
		int n;
		int i;
		int b;
		int lines;
		string cmd;
		string name;
		string line;
		arst_n = 1'b0;
		ma_data = '0;
		// Node 0 is addressed so its overflow flag shows during reset
		ma_addr = BASE;
		ma_data_valid = 1'b0;
		ma_frame_valid = 1'b0;
		sl_addr = '0;
		sl_latch_tail = 1'b0;
		in_frame_addr = '0;
		in_frame_latch_tail = '0;
		out_frame_data = '0;
		out_frame_valid = '0;
		out_frame_data_latch = '0;
		for (k = 0; k < N; k++) begin
			occ[k] = 0;
			frames[k] = 0;
			plen[k] = 0;
		end
		staged = '0;
		status_pend = 1'b0;
		// Arbiter starts with node 0 first
		last_grant = N - 1;
		err_total = 0;
		tests_pass = 0;
		tests_fail = 0;
		test_err = 0;

		cur_test = "reset";
		repeat (2) @(posedge clk);
		@(negedge clk);
		check_reset_outputs();
		repeat (3) @(posedge clk);
		arst_n <= 1'b1;
		@(negedge clk);
		check_reset_outputs();
		close_test();

		lines = 0;
		fd = $fopen("frame_testdata.txt", "r");
		if (fd == 0) begin
			cur_test = "data_file";
			report_problem("could not open frame_testdata.txt");
			close_test();
		end else begin
			while (!$feof(fd)) begin
				r = $fgets(line, fd);
				if (r > 0) lines++;
			end
			$fclose(fd);
			cycle_limit = cycles + 64 * lines;
			fd = $fopen("frame_testdata.txt", "r");
			while ($fscanf(fd, " %s", cmd) == 1) begin
				if (cmd.getc(0) == "#") begin
					r = $fgets(line, fd);
				end else if (cmd == "T") begin
					r = $fscanf(fd, " %s", name);
					if (cur_test != "") close_test();
					cur_test = name;
				end else if (cmd == "S") begin
					r = $fscanf(fd, " %h %d", a, n);
					read_bytes(fd, n);
					send_frame(a[7:0], n);
					idle_gap();
				end else if (cmd == "I") begin
					r = $fscanf(fd, " %d %d", k, n);
					read_bytes(fd, n);
					expect_input(k, n);
					idle_gap();
				end else if (cmd == "P") begin
					r = $fscanf(fd, " %d %d", k, n);
					read_bytes(fd, n);
					for (i = 0; i < n; i++) begin
						pbuf[k][i] = data_buf[i];
					end
					plen[k] = n;
					staged[k] = 1'b1;
				end else if (cmd == "B") begin
					r = $fscanf(fd, " %d %d", k, n);
					for (i = 0; i < n; i++) begin
						r = $fscanf(fd, " %h", b);
						exp_w[i] = b[8:0];
					end
					expect_slave(k, n);
					idle_gap();
				end else if (cmd == "D") begin
					drive_and_drain();
					idle_gap();
				end else if (cmd == "Z") begin
					check_quiet();
				end else begin
					report_problem({"unknown command in data file: ", cmd});
				end
			end
			$fclose(fd);
			if (cur_test != "") close_test();
		end

		$display("summary: %0d tests passed, %0d tests failed, %0d errors",
			tests_pass, tests_fail, err_total);
		if (err_total == 0 && tests_fail == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
